//--- sources.f
rtl/conv_pkg.sv
rtl/burst_reader.sv
rtl/window_mac.sv
rtl/result_writer.sv
rtl/conv_engine.sv
test/tb_dram_model.sv
test/conv_engine_tb.sv

//--- Bender.yml
package:
  name: conv_engine

sources:
  - rtl/conv_pkg.sv
  - rtl/burst_reader.sv
  - rtl/window_mac.sv
  - rtl/result_writer.sv
  - rtl/conv_engine.sv
  - target: test
    files:
      - test/tb_dram_model.sv
      - test/conv_engine_tb.sv

//--- test/conv_engine_tb.sv
`timescale 1ns/1ps

module conv_engine_tb;

    localparam int MEM_BYTES  = 512;
    localparam int RUN_CYCLES = conv_pkg::READ_BURSTS * conv_pkg::READ_PERIOD + 200;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    logic                 ready;
    conv_pkg::dram_cmd_t  in_cmd;
    conv_pkg::dram_addr_t in_addr;
    conv_pkg::byte_t      in_dout;
    logic                 in_oe;
    conv_pkg::dram_cmd_t  out_cmd;
    conv_pkg::dram_addr_t out_addr;
    conv_pkg::byte_t      out_din;
    logic                 out_oe;

    logic [31:0]     lfsr;
    string           test_name;
    conv_pkg::byte_t exp_q [$];   // Expected results, oldest first
    int              cycle        = 0;
    int              rd_cnt       = 0;
    int              last_rd      = 0;
    int              wr_grp       = 0;
    int              send_left    = 0;
    int              results_seen = 0;

    conv_engine u_conv_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_start    (start),
        .o_ready    (ready),
        .o_in_cmd   (in_cmd),
        .o_in_addr  (in_addr),
        .i_in_dout  (in_dout),
        .o_in_oe    (in_oe),
        .o_out_cmd  (out_cmd),
        .o_out_addr (out_addr),
        .o_out_din  (out_din),
        .o_out_oe   (out_oe)
    );

    tb_dram_model u_dram_model (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_cmd  (in_cmd),
        .i_addr (in_addr),
        .o_dout (in_dout)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic conv_pkg::byte_t random_byte();
        conv_pkg::byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    function automatic conv_pkg::byte_t conv_ref(input int w);
        int sum;
        sum = 0;
        for (int k = 0; k < conv_pkg::KERNEL_LEN; k++) begin
            sum += int'(u_dram_model.mem[k]) *
                   int'(u_dram_model.mem[conv_pkg::KERNEL_LEN * (1 + w) + k]);
        end
        if (sum > 127) return 8'sd127;
        if (sum < -128) return -8'sd128;
        return conv_pkg::byte_t'(sum);
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string what, input conv_pkg::byte_t exp,
                              input conv_pkg::byte_t act);
        if (act !== exp) begin
            stop_run($sformatf("** Error [%s] %s: expected %0d, got %0d",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_addr(input string what, input conv_pkg::dram_addr_t exp,
                              input conv_pkg::dram_addr_t act);
        if (act !== exp) begin
            stop_run($sformatf("** Error [%s] %s: expected 0x%h, got 0x%h",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("** Error [%s] %s: expected %0d, got %0d",
                               test_name, what, exp, act));
        end
    endtask

    task automatic fill_random();
        for (int a = 0; a < MEM_BYTES; a++) begin
            u_dram_model.mem[a] = random_byte();
        end
    endtask

    // Kernel and first eight windows at +127, everything after at -128
    task automatic fill_saturating();
        for (int a = 0; a < MEM_BYTES; a++) begin
            u_dram_model.mem[a] = (a < conv_pkg::KERNEL_LEN * (1 + conv_pkg::RESULTS_PER_BURST))
                                  ? 8'sd127 : -8'sd128;
        end
    endtask

    // Called on a rising edge, returns once ready is back
    task automatic run_conv(input string name);
        test_name    = name;
        rd_cnt       = 0;
        wr_grp       = 0;
        results_seen = 0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (ready) stop_run($sformatf("%s: start was not accepted", name));
        while (!ready) @(negedge clk);
        check_count("read bursts", conv_pkg::READ_BURSTS, rd_cnt);
        check_count("write bursts", conv_pkg::NUM_WINDOWS / conv_pkg::RESULTS_PER_BURST, wr_grp);
        check_count("results before ready", conv_pkg::NUM_WINDOWS, results_seen);
    endtask

    // Output and read monitor
    always @(negedge clk) begin
        conv_pkg::byte_t exp;
        if (rst_n) begin
            cycle++;
            if (in_cmd == conv_pkg::CMD_READ) begin
                check_addr("read address", conv_pkg::IN_BASE +
                           conv_pkg::dram_addr_t'(conv_pkg::BURST_LEN * rd_cnt), in_addr);
                if (rd_cnt > 0) check_count("read spacing", conv_pkg::READ_PERIOD, cycle - last_rd);
                last_rd = cycle;
                rd_cnt++;
            end
            if (send_left > 0) begin
                if (!out_oe) stop_run("output enable dropped inside a write burst");
                if (exp_q.size() == 0) stop_run("result written with none expected");
                exp = exp_q.pop_front();
                check_byte($sformatf("result %0d", results_seen), exp, out_din);
                send_left--;
                results_seen++;
            end else if (out_oe) begin
                stop_run("output enable high outside a write burst");
            end
            if (out_cmd == conv_pkg::CMD_WRITE) begin
                check_addr("write address", conv_pkg::OUT_BASE +
                           conv_pkg::dram_addr_t'(conv_pkg::BURST_LEN * wr_grp), out_addr);
                wr_grp++;
                send_left = conv_pkg::RESULTS_PER_BURST;
            end
        end
    end

    initial begin
        repeat (3 * RUN_CYCLES) @(posedge clk);
        stop_run("watchdog expired, the DUT hung before finishing its runs");
    end

    initial begin
        lfsr      = 32'he4f7_4315;
        test_name = "reset";
        start     = 1'b0;
        rst_n     = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (ready !== 1'b1) stop_run("o_ready low after reset");
        if (in_cmd !== conv_pkg::CMD_IDLE || out_cmd !== conv_pkg::CMD_IDLE) begin
            stop_run("a command port is not idle after reset");
        end
        if (out_oe !== 1'b0 || in_oe !== 1'b0) stop_run("an output enable is high after reset");

        fill_random();
        for (int w = 0; w < conv_pkg::NUM_WINDOWS; w++) exp_q.push_back(conv_ref(w));
        @(posedge clk);
        run_conv("random data");

        fill_saturating();
        for (int w = 0; w < conv_pkg::NUM_WINDOWS; w++) begin
            exp_q.push_back((w < conv_pkg::RESULTS_PER_BURST) ? 8'sd127 : -8'sd128);
        end
        @(posedge clk);
        run_conv("saturation");

        // Start again straight after ready returns
        fill_random();
        for (int w = 0; w < conv_pkg::NUM_WINDOWS; w++) exp_q.push_back(conv_ref(w));
        @(posedge clk);
        run_conv("back to back");

        $display("all tests passed");
        $finish;
    end

endmodule

//--- test/tb_dram_model.sv
`timescale 1ns/1ps

module tb_dram_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  conv_pkg::dram_cmd_t  i_cmd,
    input  conv_pkg::dram_addr_t i_addr,
    output conv_pkg::byte_t      o_dout
);

    localparam int MEM_BYTES = 512;
    localparam int LAST_BEAT = conv_pkg::READ_LATENCY + conv_pkg::BURST_LEN;

    conv_pkg::byte_t      mem [MEM_BYTES]; // Loaded by the testbench
    conv_pkg::dram_addr_t base;
    conv_pkg::dram_addr_t rd_addr;
    int                   beat;            // Cycles since the READ, 0 when idle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            base <= '0;
            beat <= 0;
        end else if (i_cmd == conv_pkg::CMD_READ) begin
            base <= i_addr;
            beat <= 1;
        end else if (beat != 0 && beat < LAST_BEAT) begin
            beat <= beat + 1;
        end else begin
            beat <= 0;
        end
    end

    // Bytes return in address order once the latency has passed
    assign rd_addr = base + conv_pkg::dram_addr_t'(beat - conv_pkg::READ_LATENCY - 1);
    assign o_dout  = (beat > conv_pkg::READ_LATENCY) ? mem[rd_addr % MEM_BYTES] : '0;

endmodule

//--- rtl/conv_engine.sv
`timescale 1ns/1ps

module conv_engine (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_start,
    output logic                 o_ready,
    // Input DRAM port
    output conv_pkg::dram_cmd_t  o_in_cmd,
    output conv_pkg::dram_addr_t o_in_addr,
    input  conv_pkg::byte_t      i_in_dout,
    output logic                 o_in_oe,
    // Output DRAM port
    output conv_pkg::dram_cmd_t  o_out_cmd,
    output conv_pkg::dram_addr_t o_out_addr,
    output conv_pkg::byte_t      o_out_din,
    output logic                 o_out_oe
);

    logic            start_accept;
    logic            kernel_valid;
    logic            data_valid;
    conv_pkg::byte_t stream_byte;
    logic            result_valid;
    conv_pkg::byte_t result;
    logic            run_done;

    assign start_accept = i_start & o_ready;

    burst_reader u_burst_reader (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start        (start_accept),
        .i_run_done     (run_done),
        .i_in_dout      (i_in_dout),
        .o_ready        (o_ready),
        .o_in_cmd       (o_in_cmd),
        .o_in_addr      (o_in_addr),
        .o_in_oe        (o_in_oe),
        .o_kernel_valid (kernel_valid),
        .o_data_valid   (data_valid),
        .o_byte         (stream_byte)
    );

    window_mac u_window_mac (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_kernel_valid (kernel_valid),
        .i_data_valid   (data_valid),
        .i_byte         (stream_byte),
        .o_result_valid (result_valid),
        .o_result       (result)
    );

    result_writer u_result_writer (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start        (start_accept),
        .i_result_valid (result_valid),
        .i_result       (result),
        .o_out_cmd      (o_out_cmd),
        .o_out_addr     (o_out_addr),
        .o_out_din      (o_out_din),
        .o_out_oe       (o_out_oe),
        .o_run_done     (run_done)
    );

endmodule

//--- rtl/result_writer.sv
`timescale 1ns/1ps

module result_writer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_start,
    input  logic                 i_result_valid,
    input  conv_pkg::byte_t      i_result,
    output conv_pkg::dram_cmd_t  o_out_cmd,
    output conv_pkg::dram_addr_t o_out_addr,
    output conv_pkg::byte_t      o_out_din,
    output logic                 o_out_oe,
    output logic                 o_run_done
);

    typedef enum logic [1:0] {
        IDLE,
        COMMAND,
        SEND
    } state_t;

    state_t               state;
    conv_pkg::byte_t      collect  [conv_pkg::RESULTS_PER_BURST];
    conv_pkg::byte_t      send_buf [conv_pkg::RESULTS_PER_BURST];
    logic [2:0]           col_cnt;
    logic [2:0]           send_cnt;
    logic [1:0]           grp_cnt; // Groups commanded this run
    conv_pkg::dram_addr_t addr;
    logic                 group_full;
    logic                 last_group;

    assign group_full = i_result_valid && (col_cnt == 3'(conv_pkg::RESULTS_PER_BURST - 1));
    assign last_group = (grp_cnt == 2'(conv_pkg::NUM_WINDOWS / conv_pkg::RESULTS_PER_BURST));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            col_cnt    <= '0;
            send_cnt   <= '0;
            grp_cnt    <= '0;
            addr       <= conv_pkg::OUT_BASE;
            o_run_done <= 1'b0;
        end else begin
            o_run_done <= 1'b0;
            if (i_result_valid) begin
                col_cnt <= col_cnt + 3'd1;
            end
            case (state)
                IDLE: if (group_full) state <= COMMAND;
                COMMAND: begin
                    state    <= SEND;
                    send_cnt <= '0;
                    grp_cnt  <= grp_cnt + 2'd1;
                    addr     <= addr + conv_pkg::dram_addr_t'(conv_pkg::BURST_LEN);
                end
                SEND: begin
                    send_cnt <= send_cnt + 3'd1;
                    if (send_cnt == 3'(conv_pkg::RESULTS_PER_BURST - 1)) begin
                        state      <= IDLE;
                        o_run_done <= last_group;
                    end
                end
                default: state <= IDLE;
            endcase
            // New run writes from the base again
            if (i_start) begin
                col_cnt <= '0;
                grp_cnt <= '0;
                addr    <= conv_pkg::OUT_BASE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_result_valid) begin
            collect[col_cnt] <= i_result;
        end
        if (state == IDLE && group_full) begin
            for (int k = 0; k < conv_pkg::RESULTS_PER_BURST - 1; k++) begin
                send_buf[k] <= collect[k];
            end
            send_buf[conv_pkg::RESULTS_PER_BURST - 1] <= i_result;
        end else if (state == SEND) begin
            for (int k = 0; k < conv_pkg::RESULTS_PER_BURST - 1; k++) begin
                send_buf[k] <= send_buf[k + 1];
            end
        end
    end

    assign o_out_cmd  = (state == COMMAND) ? conv_pkg::CMD_WRITE : conv_pkg::CMD_IDLE;
    assign o_out_addr = addr;
    assign o_out_oe   = (state == SEND);
    assign o_out_din  = o_out_oe ? send_buf[0] : '0; // Oldest first

    // Each WRITE is followed by eight data cycles with no new command
    a_no_write_in_send: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_out_cmd == conv_pkg::CMD_WRITE) |=>
            (o_out_oe && o_out_cmd != conv_pkg::CMD_WRITE) [*8]
    ) else $error("write command overlaps a data burst");

endmodule

//--- rtl/window_mac.sv
`timescale 1ns/1ps

module window_mac (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_kernel_valid,
    input  logic            i_data_valid,
    input  conv_pkg::byte_t i_byte,
    output logic            o_result_valid,
    output conv_pkg::byte_t o_result
);

    conv_pkg::byte_t kernel      [conv_pkg::KERNEL_LEN];
    conv_pkg::byte_t window      [conv_pkg::KERNEL_LEN];
    conv_pkg::byte_t window_next [conv_pkg::KERNEL_LEN];
    logic [3:0]      data_cnt;
    logic            last_byte;
    conv_pkg::acc_t  sum;
    conv_pkg::byte_t clamped;

    assign last_byte = i_data_valid && (data_cnt == 4'(conv_pkg::KERNEL_LEN - 1));

    // Window as it looks once the current byte is in
    always_comb begin
        for (int k = 0; k < conv_pkg::KERNEL_LEN - 1; k++) begin
            window_next[k] = window[k + 1];
        end
        window_next[conv_pkg::KERNEL_LEN - 1] = i_byte;
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < conv_pkg::KERNEL_LEN; k++) begin
            sum = sum + conv_pkg::acc_t'(window_next[k]) * conv_pkg::acc_t'(kernel[k]);
        end
    end

    // Saturate to signed 8 bits
    always_comb begin
        if (sum > conv_pkg::acc_t'(127)) begin
            clamped = 8'sd127;
        end else if (sum < conv_pkg::acc_t'(-128)) begin
            clamped = -8'sd128;
        end else begin
            clamped = conv_pkg::byte_t'(sum);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_cnt       <= '0;
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= last_byte;
            if (i_data_valid) begin
                data_cnt <= data_cnt + 4'd1; // Wraps every window
            end
        end
    end

    // Oldest byte at index 0
    always_ff @(posedge clk) begin
        if (i_kernel_valid) begin
            for (int k = 0; k < conv_pkg::KERNEL_LEN - 1; k++) begin
                kernel[k] <= kernel[k + 1];
            end
            kernel[conv_pkg::KERNEL_LEN - 1] <= i_byte;
        end
        if (i_data_valid) begin
            window <= window_next;
        end
        if (last_byte) begin
            o_result <= clamped;
        end
    end

    // A window takes 16 data bytes, so results are never back to back
    a_result_gap: assert property (
        @(posedge clk) disable iff (!rst_n)
        o_result_valid |=> !o_result_valid
    ) else $error("result valid on consecutive cycles");

endmodule

//--- rtl/burst_reader.sv
`timescale 1ns/1ps

module burst_reader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_start,
    input  logic                 i_run_done,
    input  conv_pkg::byte_t      i_in_dout,
    output logic                 o_ready,
    output conv_pkg::dram_cmd_t  o_in_cmd,
    output conv_pkg::dram_addr_t o_in_addr,
    output logic                 o_in_oe,
    output logic                 o_kernel_valid,
    output logic                 o_data_valid,
    output conv_pkg::byte_t      o_byte
);

    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        WAIT,
        RECEIVE,
        DRAIN
    } state_t;

    state_t               state;
    logic [3:0]           cyc_cnt;   // Latency and byte position
    logic [5:0]           burst_cnt; // Bursts fully received
    conv_pkg::dram_addr_t addr;
    logic                 receiving;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            cyc_cnt   <= '0;
            burst_cnt <= '0;
            addr      <= conv_pkg::IN_BASE;
        end else begin
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state     <= REQUEST;
                        burst_cnt <= '0;
                        addr      <= conv_pkg::IN_BASE;
                    end
                end
                REQUEST: begin
                    state   <= WAIT;
                    cyc_cnt <= '0;
                    addr    <= addr + conv_pkg::dram_addr_t'(conv_pkg::BURST_LEN);
                end
                WAIT: begin
                    cyc_cnt <= cyc_cnt + 4'd1;
                    if (cyc_cnt == 4'(conv_pkg::READ_LATENCY - 1)) begin
                        state   <= RECEIVE;
                        cyc_cnt <= '0;
                    end
                end
                RECEIVE: begin
                    cyc_cnt <= cyc_cnt + 4'd1;
                    if (cyc_cnt == 4'(conv_pkg::BURST_LEN - 1)) begin
                        burst_cnt <= burst_cnt + 6'd1;
                        if (burst_cnt == 6'(conv_pkg::READ_BURSTS - 1)) begin
                            state <= DRAIN;
                        end else begin
                            state <= REQUEST;
                        end
                    end
                end
                DRAIN: begin
                    // Hold until the last output burst has gone out
                    if (i_run_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign o_ready   = (state == IDLE);
    assign o_in_cmd  = (state == REQUEST) ? conv_pkg::CMD_READ : conv_pkg::CMD_IDLE;
    assign o_in_addr = addr;
    assign o_in_oe   = 1'b0; // Read only

    // Leading bursts carry the kernel
    assign receiving      = (state == RECEIVE);
    assign o_kernel_valid = receiving && (burst_cnt < 6'(conv_pkg::KERNEL_BURSTS));
    assign o_data_valid   = receiving && (burst_cnt >= 6'(conv_pkg::KERNEL_BURSTS));
    assign o_byte         = i_in_dout;

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(o_kernel_valid && o_data_valid)
    ) else $error("kernel and data strobes high together");

endmodule

//--- rtl/conv_pkg.sv
package conv_pkg;

    // Pixel, weight and result byte
    typedef logic signed [7:0]  byte_t;
    typedef logic        [31:0] dram_addr_t;
    typedef logic        [1:0]  dram_cmd_t;

    // Wide enough for 16 products of two signed bytes
    typedef logic signed [31:0] acc_t;

    // DRAM command codes
    localparam dram_cmd_t CMD_IDLE  = 2'd0;
    localparam dram_cmd_t CMD_READ  = 2'd1;
    localparam dram_cmd_t CMD_WRITE = 2'd2;

    localparam int BURST_LEN  = 8;  // Bytes per burst
    localparam int KERNEL_LEN = 16; // 4x4 bytes

    // Run shape
    localparam int KERNEL_BURSTS = 2;
    localparam int NUM_WINDOWS   = 16;
    localparam int READ_BURSTS   = KERNEL_BURSTS + 2 * NUM_WINDOWS;

    // Input port timing
    localparam int READ_LATENCY = 2;
    localparam int READ_PERIOD  = 1 + READ_LATENCY + BURST_LEN;

    localparam int RESULTS_PER_BURST = 8;

    // Base addresses of the input and output regions
    localparam dram_addr_t IN_BASE  = 32'h0000_0000;
    localparam dram_addr_t OUT_BASE = 32'h0000_0000;

endpackage
